//--- Bender.yml
package:
  name: host_mem_map

sources:
  - files:
      - hdl/axi_mem_pkg.sv
      - hdl/host_mem_pkg.sv
      - hdl/burst_splitter.sv
      - hdl/rob_credit_ctrl.sv
      - hdl/rob_buffer.sv
      - hdl/host_mem_map.sv
  - target: test
    files:
      - test/host_mem_model.sv
      - test/host_mem_map_tb.sv

//--- hdl/axi_mem_pkg.sv
// Accelerator-side read port definitions
// Field widths of the accelerator read channel, the beat size and the
// packed request and response structs exchanged with the accelerator

package axi_mem_pkg;

    // Byte address width of the accelerator port
    localparam int addr_w = 32;

    // Width of one read data beat
    localparam int data_w = 64;

    // Read transaction ID width
    localparam int id_w = 4;

    // Burst length field, encoded as beats minus one as on AXI
    localparam int afu_len_w = 8;

    // Bytes carried by one beat. Every address on the port is beat aligned
    localparam int line_bytes = 8;

    // Read address request as issued by the accelerator
    typedef struct packed {
        logic [id_w-1:0]      id;
        logic [addr_w-1:0]    addr;
        logic [afu_len_w-1:0] len;
    } afu_rd_req_t;

    // Read data beat returned to the accelerator
    // The last flag marks the final beat of the original accelerator burst
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [data_w-1:0] data;
        logic              last;
    } afu_rd_rsp_t;

endpackage

//--- hdl/burst_splitter.sv
// Read burst splitter
// Cuts each accelerator read burst into host bursts of at most
// host_max_beats beats. With natural alignment each piece is also an
// aligned power-of-two block. Pieces leave on a registered valid/ready
// port together with the accelerator id and an end-of-burst flag
`timescale 1ns/1ps

module burst_splitter
    import axi_mem_pkg::*;
    import host_mem_pkg::*;
#(
    parameter int natural_alignment = 0
)
(
    input  logic            clk,
    input  logic            arst_n,
    input  afu_rd_req_t     afu_req,
    input  logic            afu_req_valid,
    output logic            afu_req_ready,
    output host_rd_req_t    split_req,
    output logic [id_w-1:0] split_id,
    output logic            split_end,
    output logic            split_valid,
    input  logic            split_ready
);

    localparam int line_off_w = $clog2(line_bytes);
    // Beat counts run up to 2**afu_len_w, one bit more than the len field
    localparam int beats_w = afu_len_w + 1;

    // Address and beat count still owed for the burst in progress
    logic [addr_w-1:0]     rem_addr;
    logic [beats_w-1:0]    rem_beats;

    logic                  take_afu;
    logic                  take_split;
    logic [addr_w-1:0]     src_addr;
    logic [beats_w-1:0]    src_beats;
    logic [host_len_w-1:0] beat_idx;
    logic [beats_w-1:0]    piece_beats;
    logic [host_len_w:0]   piece_end_idx;

    assign take_afu   = afu_req_valid && afu_req_ready;
    assign take_split = split_valid && split_ready;

    // The next piece comes from a fresh burst on accept, otherwise from the remainder
    always_comb
    begin
        if (take_afu)
        begin
            src_addr  = afu_req.addr;
            src_beats = beats_w'(afu_req.len) + 1'b1;
        end
        else
        begin
            src_addr  = rem_addr;
            src_beats = rem_beats;
        end
    end

    // Beat position inside the enclosing host_max_beats block
    assign beat_idx = src_addr[line_off_w +: host_len_w];

    // Piece size selection
    always_comb
    begin
        if (natural_alignment != 0)
        begin
            // Grow the piece while the start stays aligned to the larger size
            // and enough beats remain. Alignment to 2**k implies alignment to
            // every smaller power, so the last hit is the largest legal piece
            piece_beats = beats_w'(1);
            for (int k = 1; k <= host_len_w; k++)
            begin
                if (src_beats >= beats_w'(1 << k) &&
                    (beat_idx & host_len_w'((1 << k) - 1)) == '0)
                begin
                    piece_beats = beats_w'(1 << k);
                end
            end
        end
        else if (src_beats > beats_w'(host_max_beats))
        begin
            piece_beats = beats_w'(host_max_beats);
        end
        else
        begin
            piece_beats = src_beats;
        end
    end

    // Handshake control. Ready is only raised while no piece is pending,
    // so a new burst is never accepted on top of a running one
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            afu_req_ready <= 1'b0;
            split_valid   <= 1'b0;
        end
        else if (take_afu)
        begin
            afu_req_ready <= 1'b0;
            split_valid   <= 1'b1;
        end
        else if (take_split)
        begin
            // The final piece frees the input in the same edge
            split_valid   <= !split_end;
            afu_req_ready <= split_end;
        end
        else if (!split_valid)
        begin
            // Idle after reset
            afu_req_ready <= 1'b1;
        end
    end

    // Piece payload and remainder, loaded on each new piece
    always_ff @(posedge clk)
    begin
        if (take_afu || (take_split && !split_end))
        begin
            split_req.addr <= src_addr;
            split_req.len  <= host_len_w'(piece_beats - 1'b1);
            // Tag is filled in by the credit controller
            split_req.tag  <= '0;
            split_end      <= (src_beats == piece_beats);
            rem_addr       <= src_addr + (addr_w'(piece_beats) << line_off_w);
            rem_beats      <= src_beats - piece_beats;
        end
        if (take_afu)
        begin
            split_id <= afu_req.id;
        end
    end

    // Index of the last beat of the emitted piece within its block
    assign piece_end_idx = {1'b0, split_req.addr[line_off_w +: host_len_w]} +
                           {1'b0, split_req.len};

    // A piece that passes the end of its block would cross a host boundary
    a_no_block_cross: assert property (@(posedge clk) disable iff (!arst_n)
        (split_valid && natural_alignment != 0) |->
            piece_end_idx < (host_len_w + 1)'(host_max_beats));

endmodule

//--- hdl/host_mem_map.sv
// Host memory read adapter top level
// Chains the burst splitter, the credit and tag controller and the
// reorder buffer between the accelerator read port and the host port
`timescale 1ns/1ps

module host_mem_map
    import axi_mem_pkg::*;
    import host_mem_pkg::*;
#(
    parameter int rob_lines         = 32,
    parameter int natural_alignment = 0
)
(
    input  logic         clk,
    input  logic         arst_n,
    input  afu_rd_req_t  afu_req,
    input  logic         afu_req_valid,
    output logic         afu_req_ready,
    output afu_rd_rsp_t  afu_rsp,
    output logic         afu_rsp_valid,
    input  logic         afu_rsp_ready,
    output host_rd_req_t host_req,
    output logic         host_req_valid,
    input  logic         host_req_ready,
    input  host_rd_rsp_t host_rsp,
    input  logic         host_rsp_valid,
    output logic         host_rsp_ready
);

    localparam int idx_w = $clog2(rob_lines);

    // The ring index must wrap on its own and fit in the host user field
    if ((rob_lines & (rob_lines - 1)) != 0 || rob_lines > (1 << host_tag_w) ||
        rob_lines < host_max_beats)
    begin : g_bad_rob_lines
        $error("rob_lines must be a power of two between %0d and %0d",
               host_max_beats, 1 << host_tag_w);
    end

    // Splitter to controller
    host_rd_req_t        split_req;
    logic [id_w-1:0]     split_id;
    logic                split_end;
    logic                split_valid;
    logic                split_ready;

    // Controller to reorder buffer
    logic [idx_w-1:0]    alloc_base;
    logic [host_len_w:0] alloc_beats;
    logic [id_w-1:0]     alloc_id;
    logic                alloc_end;
    logic                alloc_valid;
    logic                line_free;

    burst_splitter #(
        .natural_alignment(natural_alignment)
    ) u_burst_splitter (
        .clk,
        .arst_n,
        .afu_req,
        .afu_req_valid,
        .afu_req_ready,
        .split_req,
        .split_id,
        .split_end,
        .split_valid,
        .split_ready
    );

    rob_credit_ctrl #(
        .rob_lines(rob_lines)
    ) u_rob_credit_ctrl (
        .clk,
        .arst_n,
        .split_req,
        .split_id,
        .split_end,
        .split_valid,
        .split_ready,
        .host_req,
        .host_req_valid,
        .host_req_ready,
        .alloc_base,
        .alloc_beats,
        .alloc_id,
        .alloc_end,
        .alloc_valid,
        .line_free
    );

    rob_buffer #(
        .rob_lines(rob_lines)
    ) u_rob_buffer (
        .clk,
        .arst_n,
        .alloc_base,
        .alloc_beats,
        .alloc_id,
        .alloc_end,
        .alloc_valid,
        .host_rsp,
        .host_rsp_valid,
        .host_rsp_ready,
        .afu_rsp,
        .afu_rsp_valid,
        .afu_rsp_ready,
        .line_free
    );

endmodule

//--- hdl/host_mem_pkg.sv
// Host memory port definitions
// Burst limit and user tag width of the host port, and the packed
// request and response structs that travel on it

package host_mem_pkg;

    // Address and data widths follow the accelerator side
    import axi_mem_pkg::*;

    // Host burst length field holds beats minus one
    localparam int host_len_w = 2;

    // Largest number of beats in one host burst
    localparam int host_max_beats = 1 << host_len_w;

    // User field width, carries the reorder buffer base index of a burst
    localparam int host_tag_w = 6;

    // Read request sent to the host port
    typedef struct packed {
        logic [addr_w-1:0]     addr;
        logic [host_len_w-1:0] len;
        logic [host_tag_w-1:0] tag;
    } host_rd_req_t;

    // Read beat returned by the host, tag echoes the request user field
    typedef struct packed {
        logic [host_tag_w-1:0] tag;
        logic [data_w-1:0]     data;
        logic                  last;
    } host_rd_rsp_t;

endpackage

//--- hdl/rob_buffer.sv
// Read reorder buffer
// Host beats land at their tag base plus beat offset, possibly out of
// burst order. The head pointer drains filled lines in issue order to
// the accelerator and returns one credit per drained line
`timescale 1ns/1ps

module rob_buffer
    import axi_mem_pkg::*;
    import host_mem_pkg::*;
#(
    parameter int rob_lines = 32
)
(
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic [$clog2(rob_lines)-1:0] alloc_base,
    input  logic [host_len_w:0]          alloc_beats,
    input  logic [id_w-1:0]              alloc_id,
    input  logic                         alloc_end,
    input  logic                         alloc_valid,
    input  host_rd_rsp_t                 host_rsp,
    input  logic                         host_rsp_valid,
    output logic                         host_rsp_ready,
    output afu_rd_rsp_t                  afu_rsp,
    output logic                         afu_rsp_valid,
    input  logic                         afu_rsp_ready,
    output logic                         line_free
);

    localparam int idx_w = $clog2(rob_lines);

    // Line storage
    logic [data_w-1:0]     line_data [rob_lines];
    logic [id_w-1:0]       line_id   [rob_lines];
    logic [rob_lines-1:0]  line_last;
    // Set when the host beat for a line has been written
    logic [rob_lines-1:0]  line_filled;

    // Beat position within the host burst currently arriving
    logic [host_len_w-1:0] beat_off;
    logic [idx_w-1:0]      wr_line;
    logic [idx_w-1:0]      head;
    logic                  drain;

    // Credits reserve a line for every beat in flight
    assign host_rsp_ready = 1'b1;

    // Beats of one host burst arrive back to back, so a single running
    // offset is enough to place them
    assign wr_line = idx_w'(host_rsp.tag) + idx_w'(beat_off);

    // Payload writes
    always_ff @(posedge clk)
    begin
        // Stamp id and last flag on every line of a newly issued burst.
        // Only the final line of a burst that ends the accelerator burst
        // carries last
        if (alloc_valid)
        begin
            for (int k = 0; k < host_max_beats; k++)
            begin
                if (k < alloc_beats)
                begin
                    line_id[alloc_base + idx_w'(k)]   <= alloc_id;
                    line_last[alloc_base + idx_w'(k)] <= alloc_end && (k == alloc_beats - 1);
                end
            end
        end
        if (host_rsp_valid)
        begin
            line_data[wr_line] <= host_rsp.data;
        end
    end

    // Fill state, arrival offset and drain pointer
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            line_filled <= '0;
            beat_off    <= '0;
            head        <= '0;
        end
        else
        begin
            if (host_rsp_valid)
            begin
                // The line becomes visible to the head one cycle later
                line_filled[wr_line] <= 1'b1;
                beat_off             <= host_rsp.last ? '0 : beat_off + 1'b1;
            end
            // A freshly written line is never the one being drained
            if (drain)
            begin
                line_filled[head] <= 1'b0;
                head              <= head + 1'b1;
            end
        end
    end

    // The head is presented as soon as its beat is present
    assign afu_rsp_valid = line_filled[head];
    assign drain         = afu_rsp_valid && afu_rsp_ready;
    assign afu_rsp       = '{id: line_id[head], data: line_data[head], last: line_last[head]};

    // One credit back per line handed to the accelerator
    assign line_free = drain;

    // A filled line that is hit again means credits or tags went wrong upstream
    a_no_overwrite: assert property (@(posedge clk) disable iff (!arst_n)
        host_rsp_valid |-> !line_filled[wr_line]);

endmodule

//--- hdl/rob_credit_ctrl.sv
// Reorder buffer credit and tag controller
// Counts free reorder buffer lines, holds back a host burst until every
// one of its beats has a line, stamps the ring base index into the host
// user tag and reports each allocation to the reorder buffer
`timescale 1ns/1ps

module rob_credit_ctrl
    import axi_mem_pkg::*;
    import host_mem_pkg::*;
#(
    parameter int rob_lines = 32
)
(
    input  logic                         clk,
    input  logic                         arst_n,
    input  host_rd_req_t                 split_req,
    input  logic [id_w-1:0]              split_id,
    input  logic                         split_end,
    input  logic                         split_valid,
    output logic                         split_ready,
    output host_rd_req_t                 host_req,
    output logic                         host_req_valid,
    input  logic                         host_req_ready,
    output logic [$clog2(rob_lines)-1:0] alloc_base,
    output logic [host_len_w:0]          alloc_beats,
    output logic [id_w-1:0]              alloc_id,
    output logic                         alloc_end,
    output logic                         alloc_valid,
    input  logic                         line_free
);

    localparam int idx_w = $clog2(rob_lines);

    // Free line count, one bit wider so that the full count fits
    logic [idx_w:0]      free_cnt;
    // Next line to hand out, lines are allocated and freed in ring order
    logic [idx_w-1:0]    alloc_ptr;

    logic [host_len_w:0] need;
    logic [idx_w:0]      take_cnt;
    logic                credit_ok;
    logic                issue;

    // Lines needed by the pending piece, one per beat
    assign need      = {1'b0, split_req.len} + 1'b1;
    assign credit_ok = free_cnt >= (idx_w + 1)'(need);

    // Issue is combinational from the splitter, gated only by credits
    assign host_req_valid = split_valid && credit_ok;
    assign split_ready    = host_req_ready && credit_ok;
    assign issue          = host_req_valid && host_req_ready;

    // The host echoes the tag, which locates the burst in the reorder buffer
    always_comb
    begin
        host_req     = split_req;
        host_req.tag = host_tag_w'(alloc_ptr);
    end

    // The reorder buffer learns about each burst in the edge it is issued,
    // before the first host beat can arrive
    assign alloc_valid = issue;
    assign alloc_base  = alloc_ptr;
    assign alloc_beats = need;
    assign alloc_id    = split_id;
    assign alloc_end   = split_end;

    assign take_cnt = issue ? (idx_w + 1)'(need) : '0;

    // Lines are taken on issue and returned one per drained beat
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            free_cnt  <= (idx_w + 1)'(rob_lines);
            alloc_ptr <= '0;
        end
        else
        begin
            free_cnt <= free_cnt - take_cnt + (idx_w + 1)'(line_free);
            if (issue)
            begin
                // Wraps naturally since rob_lines is a power of two
                alloc_ptr <= alloc_ptr + idx_w'(need);
            end
        end
    end

    // An underflow wraps to a large value and is caught here as well
    a_credit_range: assert property (@(posedge clk) disable iff (!arst_n)
        free_cnt <= (idx_w + 1)'(rob_lines));

    // The reorder buffer may only free a line that was handed out
    a_free_outstanding: assert property (@(posedge clk) disable iff (!arst_n)
        line_free |-> free_cnt < (idx_w + 1)'(rob_lines));

endmodule

//--- src.f
hdl/axi_mem_pkg.sv
hdl/host_mem_pkg.sv
hdl/burst_splitter.sv
hdl/rob_credit_ctrl.sv
hdl/rob_buffer.sv
hdl/host_mem_map.sv
test/host_mem_model.sv
test/host_mem_map_tb.sv

//--- test/host_mem_map_tb.sv
// Testbench for the host memory read adapter
// Random accelerator bursts against an out of order host model, a
// scoreboard of expected beats in request order, host request shape
// checks, the reorder line bound, reset checks and a cycle limit
`timescale 1ns/1ps

module host_mem_map_tb
    import axi_mem_pkg::*;
    import host_mem_pkg::*;
();

    localparam int rob_lines   = 32;
    localparam int num_bursts  = 200;
    localparam int max_beats   = 16;
    // Eight cycles per beat of the longest bursts plus room for reset and drain
    localparam int cycle_limit = num_bursts * max_beats * 8 + 2000;
    localparam logic [data_w-addr_w-1:0] data_pattern = 32'h5EED_C0DE;

    logic         clk;
    logic         arst_n;
    afu_rd_req_t  afu_req;
    logic         afu_req_valid;
    logic         afu_req_ready;
    afu_rd_rsp_t  afu_rsp;
    logic         afu_rsp_valid;
    logic         afu_rsp_ready;
    host_rd_req_t host_req;
    logic         host_req_valid;
    logic         host_req_ready;
    host_rd_rsp_t host_rsp;
    logic         host_rsp_valid;
    logic         host_rsp_ready;

    // Expected accelerator beats in request order
    afu_rd_rsp_t          exp_q [$];
    afu_rd_rsp_t          exp;
    // Next address and beats still owed by the host for each open burst
    logic [addr_w-1:0]    span_addr [$];
    int                   span_beats [$];
    // Host lines requested and not yet drained to the accelerator
    int                   outstanding = 0;
    // Host lines issued so far. The ring base of the next burst follows from it
    int                   lines_issued = 0;
    int                   host_beats;
    int                   cycle_count = 0;
    int                   stretch_left = 0;
    logic                 hold = 1'b0;
    logic                 arst_q = 1'b0;
    logic [addr_w-1:0]    req_addr;
    logic [afu_len_w-1:0] req_len;
    integer               seed = 64849;

    host_mem_map #(
        .rob_lines(rob_lines),
        .natural_alignment(1)
    ) dut (
        .clk,
        .arst_n,
        .afu_req,
        .afu_req_valid,
        .afu_req_ready,
        .afu_rsp,
        .afu_rsp_valid,
        .afu_rsp_ready,
        .host_req,
        .host_req_valid,
        .host_req_ready,
        .host_rsp,
        .host_rsp_valid,
        .host_rsp_ready
    );

    host_mem_model #(
        .pattern(data_pattern)
    ) u_host_mem (
        .clk,
        .arst_n,
        .host_req,
        .host_req_valid,
        .host_req_ready,
        .host_rsp,
        .host_rsp_valid
    );

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        if (expected !== actual)
        begin
            stop_with_failure($sformatf("Fail %s: expected %0h, actual %0h",
                                        name, expected, actual));
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Accelerator request stream with random idle gaps
    initial
    begin
        arst_n        = 1'b0;
        afu_req       = '0;
        afu_req_valid = 1'b0;
        afu_rsp_ready = 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        for (int n = 0; n < num_bursts; n++)
        begin
            @(posedge clk);
            while ({$random(seed)} % 4 == 0) @(posedge clk);
            // Beat aligned address in the low megabyte
            req_addr = {$random(seed)} & 32'h000F_FFF8;
            req_len  = {$random(seed)} % max_beats;
            afu_req_valid <= 1'b1;
            afu_req       <= '{id: id_w'($random(seed)), addr: req_addr, len: req_len};
            @(posedge clk);
            while (!afu_req_ready) @(posedge clk);
            afu_req_valid <= 1'b0;
        end
        do @(negedge clk); while (exp_q.size() != 0);
        if (span_addr.size() == 0 && outstanding == 0)
        begin
            $display("NO ERRORS");
            $finish;
        end
        else
        begin
            stop_with_failure("Host bursts or reorder lines were still open at the end");
        end
    end

    // Response backpressure comes in stretches. The long holds fill the
    // reorder buffer so that host issue has to stop on credits
    always @(posedge clk)
    begin
        if (stretch_left == 0)
        begin
            hold = ({$random(seed)} % 4) == 0;
            stretch_left = hold ? 20 + {$random(seed)} % 100 : 10 + {$random(seed)} % 50;
        end
        stretch_left = stretch_left - 1;
        afu_rsp_ready <= hold ? 1'b0 : (({$random(seed)} % 4) != 0);
    end

    // Scoreboard and protocol checks see the values from before the edge
    always @(posedge clk)
    begin
        arst_q <= arst_n;
        if (!arst_n || !arst_q)
        begin
            compare("reset afu_rsp_valid", 0, afu_rsp_valid);
            compare("reset host_req_valid", 0, host_req_valid);
            compare("reset afu_req_ready", 0, afu_req_ready);
        end
        if (afu_req_valid && afu_req_ready)
        begin
            for (int b = 0; b <= afu_req.len; b++)
            begin
                exp_q.push_back('{id: afu_req.id,
                                  data: {data_pattern, afu_req.addr + addr_w'(b * line_bytes)},
                                  last: b == afu_req.len});
            end
            span_addr.push_back(afu_req.addr);
            span_beats.push_back(afu_req.len + 1);
        end
        if (host_req_valid && host_req_ready)
        begin
            host_beats = host_req.len + 1;
            // A naturally aligned burst is a power of two at a multiple of its size
            compare("host burst size power of two", 0, host_beats & (host_beats - 1));
            compare("host alignment", 0, (host_req.addr / line_bytes) % host_beats);
            // Lines are handed out in ring order, one per beat
            compare("host tag", lines_issued % rob_lines, host_req.tag);
            lines_issued = lines_issued + host_beats;
            if (span_addr.size() == 0)
            begin
                stop_with_failure("A host request was issued with no accelerator burst open");
            end
            else
            begin
                compare("host address", span_addr[0], host_req.addr);
                compare("host beats within burst", 1, host_beats <= span_beats[0]);
                span_addr[0]  = span_addr[0] + addr_w'(host_beats * line_bytes);
                span_beats[0] = span_beats[0] - host_beats;
                if (span_beats[0] == 0)
                begin
                    span_addr.pop_front();
                    span_beats.pop_front();
                end
            end
            outstanding = outstanding + host_beats;
        end
        if (afu_rsp_valid && afu_rsp_ready)
        begin
            if (exp_q.size() == 0)
            begin
                stop_with_failure("A response beat arrived with no beat outstanding");
            end
            else
            begin
                exp = exp_q.pop_front();
                compare("rsp id", exp.id, afu_rsp.id);
                compare("rsp data", exp.data, afu_rsp.data);
                compare("rsp last", exp.last, afu_rsp.last);
                outstanding = outstanding - 1;
            end
        end
        compare("lines outstanding within rob_lines", 1, outstanding <= rob_lines);
        if (host_rsp_valid)
        begin
            compare("host_rsp_ready", 1, host_rsp_ready);
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            stop_with_failure("Timeout, the run passed its cycle limit before all beats returned");
        end
    end

endmodule

//--- test/host_mem_model.sv
// Behavioral host memory for the read adapter testbench
// Accepts host read bursts under random backpressure, queues them and
// answers one randomly chosen burst at a time with back to back beats.
// Beat data is the beat byte address with a fixed pattern above it
`timescale 1ns/1ps

module host_mem_model
    import axi_mem_pkg::*;
    import host_mem_pkg::*;
#(
    parameter logic [data_w-addr_w-1:0] pattern = '0
)
(
    input  logic         clk,
    input  logic         arst_n,
    input  host_rd_req_t host_req,
    input  logic         host_req_valid,
    output logic         host_req_ready,
    output host_rd_rsp_t host_rsp,
    output logic         host_rsp_valid
);

    // Accepted bursts whose beats have not started yet
    host_rd_req_t pending [$];
    // Burst currently being returned
    host_rd_req_t cur;
    int           beats_left;
    int           beat;
    int           pick;
    integer       seed = 64849;

    initial
    begin
        host_req_ready = 1'b0;
        host_rsp_valid = 1'b0;
        host_rsp       = '0;
        beats_left     = 0;
        beat           = 0;
    end

    always @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            host_req_ready <= 1'b0;
            host_rsp_valid <= 1'b0;
            beats_left = 0;
            pending.delete();
        end
        else
        begin
            // Roughly three requests in four find the port ready
            host_req_ready <= ({$random(seed)} % 4) != 0;
            if (host_req_valid && host_req_ready)
            begin
                pending.push_back(host_req);
            end
            // Any queued burst may go next, which returns bursts out of order
            if (beats_left == 0 && pending.size() != 0)
            begin
                pick = {$random(seed)} % pending.size();
                cur  = pending[pick];
                pending.delete(pick);
                beats_left = cur.len + 1;
                beat       = 0;
            end
            if (beats_left != 0)
            begin
                host_rsp_valid <= 1'b1;
                host_rsp <= '{tag: cur.tag,
                              data: {pattern, cur.addr + addr_w'(beat * line_bytes)},
                              last: beats_left == 1};
                beat       = beat + 1;
                beats_left = beats_left - 1;
            end
            else
            begin
                host_rsp_valid <= 1'b0;
            end
        end
    end

endmodule
